//--- source/qla_pkg.sv
// shared request and response types, register offsets and constants
`default_nettype none

package qla_pkg;

    // --------------------
    // host request types
    // --------------------

    // quadlet access kind
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } reg_op_e;

    // one host request, 49 bits
    typedef struct packed {
        reg_op_e     op;
        logic [15:0] addr;
        logic [31:0] wdata;
    } host_req_t;

    // response carries read data only
    typedef struct packed {
        logic [31:0] rdata;
    } host_resp_t;

    // write broadcast to every channel
    // paired with a one-hot channel select
    typedef struct packed {
        logic [3:0]  off;
        logic [31:0] data;
    } reg_wr_t;

    // request sequencer states
    typedef enum logic [1:0] {
        DEC_IDLE  = 2'd0,
        DEC_ISSUE = 2'd1,
        DEC_WAIT  = 2'd2
    } dec_state_e;

    // --------------------
    // address map
    // --------------------

    // addr[7:4] channel, addr[3:0] offset
    // addr[15:8] must be zero

    // axis channel offsets
    localparam logic [3:0] OFF_DAC_CMD   = 4'd0;
    localparam logic [3:0] OFF_ADC_FB    = 4'd1;
    localparam logic [3:0] OFF_AXIS_STAT = 4'd2;

    // board channel offsets
    localparam logic [3:0] OFF_BOARD_ID  = 4'd0;
    localparam logic [3:0] OFF_AMP_EN    = 4'd1;
    localparam logic [3:0] OFF_SAFETY    = 4'd2;

    // --------------------
    // data constants
    // --------------------

    // zero current in offset binary, both adc and dac
    localparam logic [15:0] MIDSCALE = 16'h8000;

    // returned by any address nobody decodes
    localparam logic [31:0] UNMAPPED_DATA = 32'hdead_0000;

endpackage

`default_nettype wire

//--- source/reg_decode.sv
// host request sequencer with channel and offset decode and write strobe
`default_nettype none

module reg_decode #(
    parameter int NUM_AXES = 4
) (
    input  logic                   sysclk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  qla_pkg::host_req_t     req,
    output logic                   req_ready,
    input  logic                   resp_done,
    output logic [NUM_AXES:0]      wr_sel,
    output qla_pkg::reg_wr_t       wr,
    output logic [3:0]             rd_off,
    output logic [3:0]             rd_chan,
    output logic                   rd_unmapped,
    output logic                   issue,
    output logic                   is_write
);

    qla_pkg::dec_state_e state;

    // request captured at acceptance, held until the next one
    qla_pkg::host_req_t req_q;

    logic [3:0] chan;
    logic       upper_bad;
    logic       chan_bad;
    logic       unmapped;

    // --------------------
    // sequencer
    // --------------------

    // one request in flight, register bus stays ordered
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= qla_pkg::DEC_IDLE;
        end else begin
            case (state)
                qla_pkg::DEC_IDLE: begin
                    if (req_valid) begin
                        state <= qla_pkg::DEC_ISSUE;
                    end
                end
                // single issue cycle, write lands on its closing edge
                qla_pkg::DEC_ISSUE: state <= qla_pkg::DEC_WAIT;
                qla_pkg::DEC_WAIT: begin
                    if (resp_done) begin
                        state <= qla_pkg::DEC_IDLE;
                    end
                end
                default: state <= qla_pkg::DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (state == qla_pkg::DEC_IDLE && req_valid) begin
            req_q <= req;
        end
    end

    assign req_ready = (state == qla_pkg::DEC_IDLE);
    assign issue     = (state == qla_pkg::DEC_ISSUE);
    assign is_write  = (req_q.op == qla_pkg::OP_WRITE);

    // --------------------
    // address decode
    // --------------------

    assign chan      = req_q.addr[7:4];
    assign upper_bad = |req_q.addr[15:8];
    // channel 0 is the board, 1..NUM_AXES the axes
    assign chan_bad  = int'(chan) > NUM_AXES;
    assign unmapped  = upper_bad || chan_bad;

    // read select held until the response is taken
    assign rd_off      = req_q.addr[3:0];
    assign rd_chan     = chan;
    assign rd_unmapped = unmapped;

    // broadcast write payload
    assign wr.off  = req_q.addr[3:0];
    assign wr.data = req_q.wdata;

    // one-hot strobe, issue cycle only
    // unmapped writes select nobody
    always_comb begin
        for (int i = 0; i <= NUM_AXES; i++) begin
            wr_sel[i] = issue && is_write && !unmapped && (chan == 4'(i));
        end
    end

endmodule

`default_nettype wire

//--- source/axis_channel.sv
// axis channel with dac command, adc feedback capture, safety latch and read port
`default_nettype none

module axis_channel #(
    parameter int          SAFETY_COUNT  = 4,
    parameter logic [15:0] SAFETY_MARGIN = 16'h0100
) (
    input  logic                sysclk,
    input  logic                rst,
    input  logic                wr_en,
    input  qla_pkg::reg_wr_t    wr,
    input  logic                clr,
    input  logic                fb_valid,
    input  logic [15:0]         fb_data,
    input  logic [3:0]          rd_off,
    output logic [31:0]         rd_data,
    output logic [15:0]         dac_cmd,
    output logic                amp_disable
);

    logic [15:0] cmd_q;
    logic [15:0] fb_q;
    logic [7:0]  streak;

    // offset binary to signed distance from zero current
    logic [16:0] fb_diff;
    logic [16:0] cmd_diff;
    logic [16:0] fb_mag;
    logic [16:0] cmd_mag;
    // 2 * |cmd| + margin needs 19 bits
    logic [18:0] limit;
    logic        bad;
    logic [7:0]  streak_next;

    // --------------------
    // registers
    // --------------------

    // command, idles at zero current
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cmd_q <= qla_pkg::MIDSCALE;
        end else if (wr_en && wr.off == qla_pkg::OFF_DAC_CMD) begin
            cmd_q <= wr.data[15:0];
        end
    end

    // feedback, captured on the shared adc strobe
    always_ff @(posedge sysclk) begin
        if (rst) begin
            fb_q <= qla_pkg::MIDSCALE;
        end else if (fb_valid) begin
            fb_q <= fb_data;
        end
    end

    assign dac_cmd = cmd_q;

    // --------------------
    // safety check
    // --------------------

    // 17-bit differences, bit 16 is the sign
    assign fb_diff  = {1'b0, fb_data} - {1'b0, qla_pkg::MIDSCALE};
    assign cmd_diff = {1'b0, cmd_q} - {1'b0, qla_pkg::MIDSCALE};

    // magnitude reaches 32768 at code 0, still fits
    assign fb_mag  = fb_diff[16] ? (~fb_diff + 17'd1) : fb_diff;
    assign cmd_mag = cmd_diff[16] ? (~cmd_diff + 17'd1) : cmd_diff;

    assign limit = {1'b0, cmd_mag, 1'b0} + {3'b000, SAFETY_MARGIN};
    assign bad   = {2'b00, fb_mag} > limit;

    // saturating bad-sample count
    assign streak_next = (streak == 8'hff) ? streak : streak + 8'd1;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            streak      <= 8'd0;
            amp_disable <= 1'b0;
        end else if (clr) begin
            // clear wins over a sample on the same edge
            streak      <= 8'd0;
            amp_disable <= 1'b0;
        end else if (fb_valid) begin
            if (bad) begin
                streak <= streak_next;
                // trips on the edge the count is reached
                if (int'(streak_next) >= SAFETY_COUNT) begin
                    amp_disable <= 1'b1;
                end
            end else begin
                // any good sample breaks the streak
                streak <= 8'd0;
            end
        end
    end

    // --------------------
    // read port
    // --------------------

    always_comb begin
        case (rd_off)
            qla_pkg::OFF_DAC_CMD:   rd_data = {16'h0000, cmd_q};
            qla_pkg::OFF_ADC_FB:    rd_data = {16'h0000, fb_q};
            // streak in 15:8, latch in bit 0
            qla_pkg::OFF_AXIS_STAT: rd_data = {16'h0000, streak, 7'd0, amp_disable};
            default:                rd_data = qla_pkg::UNMAPPED_DATA;
        endcase
    end

endmodule

`default_nettype wire

//--- source/board_regs.sv
// board channel 0 with id, amplifier enable register and latch-clear pulses
`default_nettype none

module board_regs #(
    parameter int         NUM_AXES = 4,
    parameter logic [7:0] BOARD_ID = 8'h5a
) (
    input  logic                    sysclk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  qla_pkg::reg_wr_t        wr,
    input  logic [3:0]              rd_off,
    input  logic [NUM_AXES-1:0]     amp_disable,
    output logic [31:0]             rd_data,
    output logic [NUM_AXES-1:0]     amp_en,
    output logic [NUM_AXES-1:0]     clr
);

    logic amp_en_wr;

    assign amp_en_wr = wr_en && (wr.off == qla_pkg::OFF_AMP_EN);

    // --------------------
    // enable register
    // --------------------

    // bit i-1 enables axis i, all off after reset
    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_en <= '0;
        end else if (amp_en_wr) begin
            amp_en <= wr.data[NUM_AXES-1:0];
        end
    end

    // clear pulse in the strobe cycle itself
    // so the latch clears on the same edge as the enable
    assign clr = amp_en_wr ? wr.data[NUM_AXES-1:0] : '0;

    // --------------------
    // read port
    // --------------------

    always_comb begin
        case (rd_off)
            // axis count in 11:8, id in 7:0
            qla_pkg::OFF_BOARD_ID: rd_data = {20'h00000, 4'(NUM_AXES), BOARD_ID};
            qla_pkg::OFF_AMP_EN:   rd_data = 32'(amp_en);
            // latched disables collected from the axes
            qla_pkg::OFF_SAFETY:   rd_data = 32'(amp_disable);
            default:               rd_data = qla_pkg::UNMAPPED_DATA;
        endcase
    end

endmodule

`default_nettype wire

//--- source/read_mux.sv
// read data select across channels and registered response with back-pressure
`default_nettype none

module read_mux #(
    parameter int NUM_AXES = 4
) (
    input  logic                        sysclk,
    input  logic                        rst,
    input  logic [3:0]                  rd_chan,
    input  logic                        rd_unmapped,
    input  logic [31:0]                 board_rd,
    input  logic [NUM_AXES*32-1:0]      axis_rd,
    input  logic                        issue,
    input  logic                        is_write,
    output logic                        resp_valid,
    output qla_pkg::host_resp_t         resp,
    input  logic                        resp_ready,
    output logic                        resp_done
);

    logic [31:0] sel_data;

    // --------------------
    // channel select
    // --------------------

    always_comb begin
        sel_data = board_rd;
        if (is_write) begin
            // writes answer with zero
            sel_data = 32'h0000_0000;
        end else if (rd_unmapped) begin
            sel_data = qla_pkg::UNMAPPED_DATA;
        end else begin
            // axis i lives on channel i+1
            for (int i = 0; i < NUM_AXES; i++) begin
                if (rd_chan == 4'(i + 1)) begin
                    sel_data = axis_rd[i*32 +: 32];
                end
            end
        end
    end

    // --------------------
    // response register
    // --------------------

    // data loaded once at the end of the issue cycle
    // stays put while the host stalls
    always_ff @(posedge sysclk) begin
        if (issue) begin
            resp.rdata <= sel_data;
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (issue) begin
            resp_valid <= 1'b1;
        end else if (resp_done) begin
            resp_valid <= 1'b0;
        end
    end

    // handshake tells the decoder to accept again
    assign resp_done = resp_valid && resp_ready;

endmodule

`default_nettype wire

//--- source/qla_axes.sv
// top level with request decode, board channel, axis generate loop and read mux
`default_nettype none

module qla_axes #(
    parameter int          NUM_AXES      = 4,
    parameter int          SAFETY_COUNT  = 4,
    parameter logic [15:0] SAFETY_MARGIN = 16'h0100,
    parameter logic [7:0]  BOARD_ID      = 8'h5a
) (
    input  logic                        sysclk,
    input  logic                        rst,
    // host request port
    input  logic                        req_valid,
    input  qla_pkg::host_req_t          req,
    output logic                        req_ready,
    // host response port
    output logic                        resp_valid,
    output qla_pkg::host_resp_t         resp,
    input  logic                        resp_ready,
    // parallel adc samples, one strobe for all axes
    input  logic                        fb_valid,
    input  logic [NUM_AXES*16-1:0]      fb_data,
    // parallel dac commands and amplifier enables
    output logic [NUM_AXES*16-1:0]      dac_cmd,
    output logic [NUM_AXES-1:0]         amp_out
);

    // decode to channels
    logic [NUM_AXES:0]      wr_sel;
    qla_pkg::reg_wr_t       wr;
    logic [3:0]             rd_off;
    logic [3:0]             rd_chan;
    logic                   rd_unmapped;
    logic                   issue;
    logic                   is_write;
    logic                   resp_done;

    // channels to read mux and board
    logic [31:0]            board_rd;
    logic [NUM_AXES*32-1:0] axis_rd;
    logic [NUM_AXES-1:0]    amp_en;
    logic [NUM_AXES-1:0]    amp_disable;
    logic [NUM_AXES-1:0]    clr;

    reg_decode #(.NUM_AXES(NUM_AXES)) dec (
        .sysclk(sysclk), .rst(rst),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .resp_done(resp_done),
        .wr_sel(wr_sel), .wr(wr),
        .rd_off(rd_off), .rd_chan(rd_chan), .rd_unmapped(rd_unmapped),
        .issue(issue), .is_write(is_write)
    );

    // channel 0 beside the axis loop
    board_regs #(.NUM_AXES(NUM_AXES), .BOARD_ID(BOARD_ID)) chan0 (
        .sysclk(sysclk), .rst(rst),
        .wr_en(wr_sel[0]), .wr(wr), .rd_off(rd_off),
        .amp_disable(amp_disable), .rd_data(board_rd),
        .amp_en(amp_en), .clr(clr)
    );

    // --------------------
    // axis channels
    // --------------------

    // axis i answers on channel i+1
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        axis_channel #(
            .SAFETY_COUNT(SAFETY_COUNT),
            .SAFETY_MARGIN(SAFETY_MARGIN)
        ) axis (
            .sysclk(sysclk), .rst(rst),
            .wr_en(wr_sel[i+1]), .wr(wr), .clr(clr[i]),
            .fb_valid(fb_valid), .fb_data(fb_data[i*16 +: 16]),
            .rd_off(rd_off), .rd_data(axis_rd[i*32 +: 32]),
            .dac_cmd(dac_cmd[i*16 +: 16]), .amp_disable(amp_disable[i])
        );
    end

    read_mux #(.NUM_AXES(NUM_AXES)) rmux (
        .sysclk(sysclk), .rst(rst),
        .rd_chan(rd_chan), .rd_unmapped(rd_unmapped),
        .board_rd(board_rd), .axis_rd(axis_rd),
        .issue(issue), .is_write(is_write),
        .resp_valid(resp_valid), .resp(resp), .resp_ready(resp_ready),
        .resp_done(resp_done)
    );

    // amplifier on only when enabled and not tripped
    assign amp_out = amp_en & ~amp_disable;

endmodule

`default_nettype wire

//--- verif/qla_model.svh
// reference model of the register file and safety latches, plus the xorshift generator
`ifndef QLA_MODEL_SVH
`define QLA_MODEL_SVH

// --------------------
// model state
// --------------------

logic [15:0]         exp_cmd [NUM_AXES];
logic [15:0]         exp_fb [NUM_AXES];
int                  exp_streak [NUM_AXES];
logic [NUM_AXES-1:0] exp_dis;
logic [NUM_AXES-1:0] exp_en;

// xorshift state, seeded by the testbench
logic [31:0] rng;

function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

// values right after reset
function automatic void reset_model();
    for (int a = 0; a < NUM_AXES; a++) begin
        exp_cmd[a]    = qla_pkg::MIDSCALE;
        exp_fb[a]     = qla_pkg::MIDSCALE;
        exp_streak[a] = 0;
    end
    exp_dis = '0;
    exp_en  = '0;
endfunction

// --------------------
// register access
// --------------------

// writes outside the map or to read-only offsets change nothing
function automatic void apply_write(input logic [15:0] addr, input logic [31:0] data);
    int chan;
    chan = int'(addr[7:4]);
    if (addr[15:8] != 8'h00 || chan > NUM_AXES) begin
        return;
    end
    if (chan == 0 && addr[3:0] == qla_pkg::OFF_AMP_EN) begin
        exp_en = data[NUM_AXES-1:0];
        // every bit written as one re-arms its axis
        for (int a = 0; a < NUM_AXES; a++) begin
            if (data[a]) begin
                exp_streak[a] = 0;
                exp_dis[a]    = 1'b0;
            end
        end
    end else if (chan > 0 && addr[3:0] == qla_pkg::OFF_DAC_CMD) begin
        exp_cmd[chan-1] = data[15:0];
    end
endfunction

function automatic logic [31:0] predict_read(input logic [15:0] addr);
    int          chan;
    int          a;
    logic [31:0] val;
    chan = int'(addr[7:4]);
    val  = qla_pkg::UNMAPPED_DATA;
    if (addr[15:8] == 8'h00 && chan == 0) begin
        case (addr[3:0])
            // axis count sits above the id byte
            qla_pkg::OFF_BOARD_ID: val = (NUM_AXES << 8) | 32'(BOARD_ID);
            qla_pkg::OFF_AMP_EN:   val = 32'(exp_en);
            qla_pkg::OFF_SAFETY:   val = 32'(exp_dis);
            default:               val = qla_pkg::UNMAPPED_DATA;
        endcase
    end else if (addr[15:8] == 8'h00 && chan <= NUM_AXES) begin
        a = chan - 1;
        case (addr[3:0])
            qla_pkg::OFF_DAC_CMD:   val = 32'(exp_cmd[a]);
            qla_pkg::OFF_ADC_FB:    val = 32'(exp_fb[a]);
            qla_pkg::OFF_AXIS_STAT: val = {16'h0000, exp_streak[a][7:0], 7'h00, exp_dis[a]};
            default:                val = qla_pkg::UNMAPPED_DATA;
        endcase
    end
    return val;
endfunction

// --------------------
// safety rule
// --------------------

// one adc strobe, all axes at once
function automatic void apply_sample(input logic [NUM_AXES*16-1:0] words);
    int fmag;
    int cmag;
    for (int a = 0; a < NUM_AXES; a++) begin
        fmag = int'(words[a*16 +: 16]) - 32768;
        cmag = int'(exp_cmd[a]) - 32768;
        if (fmag < 0) fmag = -fmag;
        if (cmag < 0) cmag = -cmag;
        if (fmag > 2 * cmag + int'(SAFETY_MARGIN)) begin
            if (exp_streak[a] < 255) exp_streak[a] = exp_streak[a] + 1;
            if (exp_streak[a] >= SAFETY_COUNT) exp_dis[a] = 1'b1;
        end else begin
            exp_streak[a] = 0;
        end
        exp_fb[a] = words[a*16 +: 16];
    end
endfunction

function automatic logic [NUM_AXES-1:0] predict_amp_out();
    return exp_en & ~exp_dis;
endfunction

`endif

//--- verif/qla_axes_tb.sv
// testbench with clock, reset, random register traffic, safety stimulus, watchdog and report
`default_nettype none

module qla_axes_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_AXES      = 4;
    localparam int          SAFETY_COUNT  = 4;
    localparam logic [15:0] SAFETY_MARGIN = 16'h0100;
    localparam logic [7:0]  BOARD_ID      = 8'h5a;

    // upper bound on transactions plus sample pulses over all tests
    localparam int NUM_TXN         = 300;
    localparam int MAX_STALL       = 4;
    localparam int WATCHDOG_CYCLES = NUM_TXN * 3 * (MAX_STALL + 1) + 200;

    logic                   sysclk;
    logic                   rst;
    logic                   req_valid;
    qla_pkg::host_req_t     req;
    logic                   req_ready;
    logic                   resp_valid;
    qla_pkg::host_resp_t    resp;
    logic                   resp_ready;
    logic                   fb_valid;
    logic [NUM_AXES*16-1:0] fb_data;
    logic [NUM_AXES*16-1:0] dac_cmd;
    logic [NUM_AXES-1:0]    amp_out;

    int   errors;
    int   tests_run;
    int   stall_run;
    logic stall_mode;

    `include "qla_model.svh"

    qla_axes uut (
        .sysclk(sysclk), .rst(rst),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp(resp), .resp_ready(resp_ready),
        .fb_valid(fb_valid), .fb_data(fb_data),
        .dac_cmd(dac_cmd), .amp_out(amp_out)
    );

    always #10 sysclk = ~sysclk;

    // --------------------
    // helpers
    // --------------------

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error %s: expected %h, actual %h", name, exp, act);
        errors++;
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    function automatic logic [15:0] axis_addr(input int a, input logic [3:0] off);
        return {8'h00, 4'(a + 1), off};
    endfunction

    function automatic logic [NUM_AXES*16-1:0] random_words();
        logic [NUM_AXES*16-1:0] w;
        logic [31:0]            r;
        for (int a = 0; a < NUM_AXES; a++) begin
            r = next_rand();
            w[a*16 +: 16] = r[15:0];
        end
        return w;
    endfunction

    // masked axes sit twice the margin off midscale and the rest at zero current
    function automatic logic [NUM_AXES*16-1:0] fault_words(input logic [NUM_AXES-1:0] mask);
        logic [NUM_AXES*16-1:0] w;
        logic [31:0]            r;
        w = {NUM_AXES{qla_pkg::MIDSCALE}};
        for (int a = 0; a < NUM_AXES; a++) begin
            r = next_rand();
            if (mask[a]) w[a*16 +: 16] = r[0] ? 16'h8200 : 16'h7e00;
        end
        return w;
    endfunction

    // mostly mapped addresses plus some above the axis count or with a nonzero upper byte
    function automatic logic [15:0] random_addr(input logic [31:0] r);
        logic [3:0] chan;
        chan = 4'(int'(r[9:8]) % NUM_AXES + 1);
        case (r[2:0])
            3'd0, 3'd1, 3'd2, 3'd3: return {8'h00, chan, 2'b00, r[13:12]};
            3'd4, 3'd5:             return {8'h00, 4'h0, 2'b00, r[13:12]};
            3'd6:                   return {8'h00, 1'b1, r[11:9], r[15:12]};
            default:                return {r[23:16] | 8'h01, r[7:0]};
        endcase
    endfunction

    // stalls bounded to MAX_STALL in a row
    task automatic drive_ready();
        logic [31:0] r;
        r = next_rand();
        if (stall_mode && stall_run < MAX_STALL && r[0]) begin
            resp_ready = 1'b0;
            stall_run++;
        end else begin
            resp_ready = 1'b1;
            stall_run  = 0;
        end
    endtask

    // one adc strobe entered and left 2 ns after an edge
    task automatic pulse_sample(input logic [NUM_AXES*16-1:0] words, input logic valid);
        fb_data  = words;
        fb_valid = valid;
        @(posedge sysclk);
        #2;
        fb_valid = 1'b0;
        if (valid) apply_sample(words);
    endtask

    // full request and response with the prediction taken before issue
    task automatic access(input qla_pkg::reg_op_e op, input logic [15:0] addr,
                          input logic [31:0] wdata, input string name);
        logic [31:0] exp;
        logic [31:0] held;
        logic        seen;
        logic        done;
        exp = (op == qla_pkg::OP_READ) ? predict_read(addr) : 32'h0000_0000;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge sysclk);
            #2;
        end
        @(posedge sysclk);
        #2;
        req_valid = 1'b0;
        seen = 1'b0;
        done = 1'b0;
        held = 32'h0;
        // pending until the handshake edge
        while (!done) begin
            drive_ready();
            if (req_ready) begin
                $display("req_ready went high while a response was pending (%s)", name);
                errors++;
            end
            if (resp_valid) begin
                if (seen && resp.rdata !== held) begin
                    $display("response data changed while stalled (%s)", name);
                    errors++;
                end
                held = resp.rdata;
                seen = 1'b1;
                if (resp_ready) done = 1'b1;
            end
            @(posedge sysclk);
            #2;
        end
        if (held !== exp) report_mismatch(name, exp, held);
        if (op == qla_pkg::OP_WRITE) apply_write(addr, wdata);
    endtask

    // --------------------
    // tests
    // --------------------

    task automatic reset_state();
        int start;
        start = errors;
        if (req_ready !== 1'b1 || resp_valid !== 1'b0) begin
            $display("host port not idle after reset");
            errors++;
        end
        if (amp_out !== '0) report_mismatch("reset amp_out", '0, 32'(amp_out));
        for (int a = 0; a < NUM_AXES; a++) begin
            if (dac_cmd[a*16 +: 16] !== qla_pkg::MIDSCALE) begin
                report_mismatch("reset dac_cmd", 32'(qla_pkg::MIDSCALE),
                                32'(dac_cmd[a*16 +: 16]));
            end
            access(qla_pkg::OP_READ, axis_addr(a, qla_pkg::OFF_AXIS_STAT), 0, "reset stat");
        end
        access(qla_pkg::OP_READ, {12'h000, qla_pkg::OFF_SAFETY}, 0, "reset safety");
        end_test("reset_state", start);
    endtask

    task automatic dac_readback();
        int          start;
        int          a;
        logic [31:0] r;
        start = errors;
        for (int n = 0; n < 16; n++) begin
            r = next_rand();
            a = int'(r[17:16]) % NUM_AXES;
            access(qla_pkg::OP_WRITE, axis_addr(a, qla_pkg::OFF_DAC_CMD), r, "dac write");
            // port follows the register straight away
            for (int k = 0; k < NUM_AXES; k++) begin
                if (dac_cmd[k*16 +: 16] !== exp_cmd[k]) begin
                    report_mismatch("dac_cmd port", 32'(exp_cmd[k]), 32'(dac_cmd[k*16 +: 16]));
                end
            end
            access(qla_pkg::OP_READ, axis_addr(a, qla_pkg::OFF_DAC_CMD), 0, "dac readback");
        end
        end_test("dac_readback", start);
    endtask

    task automatic feedback_capture();
        int          start;
        logic [31:0] r;
        start = errors;
        for (int n = 0; n < 12; n++) begin
            r = next_rand();
            // a quarter of the rounds move fb_data without a strobe
            pulse_sample(random_words(), r[1:0] != 2'b00);
            for (int a = 0; a < NUM_AXES; a++) begin
                access(qla_pkg::OP_READ, axis_addr(a, qla_pkg::OFF_ADC_FB), 0, "adc readback");
            end
        end
        end_test("feedback_capture", start);
    endtask

    task automatic safety_trip();
        int start;
        start = errors;
        // re-arm everything and zero the current commands
        access(qla_pkg::OP_WRITE, {12'h000, qla_pkg::OFF_AMP_EN}, '1, "trip enable");
        for (int a = 0; a < NUM_AXES; a++) begin
            access(qla_pkg::OP_WRITE, axis_addr(a, qla_pkg::OFF_DAC_CMD),
                   32'(qla_pkg::MIDSCALE), "trip cmd");
        end
        for (int a = 0; a < NUM_AXES; a++) begin
            repeat (SAFETY_COUNT - 1) pulse_sample(fault_words(NUM_AXES'(1) << a), 1'b1);
            if (amp_out[a] !== 1'b1) begin
                $display("axis %0d tripped before its streak was complete", a + 1);
                errors++;
            end
            // one good sample restarts the count
            pulse_sample(fault_words('0), 1'b1);
            repeat (SAFETY_COUNT) pulse_sample(fault_words(NUM_AXES'(1) << a), 1'b1);
            if (amp_out[a] !== 1'b0) begin
                $display("axis %0d stayed enabled after a full bad streak", a + 1);
                errors++;
            end
            if (amp_out !== predict_amp_out()) begin
                report_mismatch("trip amp_out", 32'(predict_amp_out()), 32'(amp_out));
            end
            access(qla_pkg::OP_READ, axis_addr(a, qla_pkg::OFF_AXIS_STAT), 0, "trip stat");
            access(qla_pkg::OP_READ, {12'h000, qla_pkg::OFF_SAFETY}, 0, "trip safety");
        end
        end_test("safety_trip", start);
    endtask

    task automatic clear_reenable();
        int                  start;
        logic [31:0]         r;
        logic [NUM_AXES-1:0] bits;
        start = errors;
        repeat (2) begin
            // build up streaks first so the clear has something to zero
            pulse_sample(fault_words('1), 1'b1);
            pulse_sample(fault_words('1), 1'b1);
            r    = next_rand();
            bits = r[NUM_AXES-1:0];
            access(qla_pkg::OP_WRITE, {12'h000, qla_pkg::OFF_AMP_EN}, 32'(bits), "amp_en write");
            if (amp_out !== bits) report_mismatch("amp_out restore", 32'(bits), 32'(amp_out));
            for (int a = 0; a < NUM_AXES; a++) begin
                access(qla_pkg::OP_READ, axis_addr(a, qla_pkg::OFF_AXIS_STAT), 0, "clear stat");
            end
            access(qla_pkg::OP_READ, {12'h000, qla_pkg::OFF_AMP_EN}, 0, "amp_en readback");
        end
        end_test("clear_reenable", start);
    endtask

    task automatic board_and_unmapped();
        int          start;
        logic [15:0] holes [10];
        start = errors;
        holes = '{16'h0050, 16'h00f0, 16'h0100, 16'h8010, 16'h0013,
                  16'h004f, 16'h0003, 16'h0110, 16'h0101, 16'h0011};
        access(qla_pkg::OP_READ, {12'h000, qla_pkg::OFF_BOARD_ID}, 0, "board id");
        for (int n = 0; n < 10; n++) begin
            access(qla_pkg::OP_READ, holes[n], 0, "unmapped read");
        end
        // shadows of real registers and read-only offsets
        for (int n = 0; n < 10; n++) begin
            access(qla_pkg::OP_WRITE, holes[n], next_rand(), "unmapped write");
        end
        access(qla_pkg::OP_WRITE, 16'h0000, next_rand(), "id write");
        for (int c = 0; c <= NUM_AXES; c++) begin
            for (int off = 0; off < 3; off++) begin
                access(qla_pkg::OP_READ, {8'h00, 4'(c), 4'(off)}, 0, "post write readback");
            end
        end
        end_test("board_and_unmapped", start);
    endtask

    task automatic backpressure_order();
        int          start;
        logic [31:0] r;
        start = errors;
        stall_mode = 1'b1;
        for (int n = 0; n < 40; n++) begin
            r = next_rand();
            if (r[30:28] == 3'd0) pulse_sample(random_words(), 1'b1);
            access(r[31] ? qla_pkg::OP_WRITE : qla_pkg::OP_READ, random_addr(r),
                   next_rand(), "ordered response");
        end
        stall_mode = 1'b0;
        end_test("backpressure_order", start);
    endtask

    // --------------------
    // run
    // --------------------

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("watchdog expired: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        errors     = 0;
        tests_run  = 0;
        stall_run  = 0;
        stall_mode = 1'b0;
        rng        = 32'ha331_56a4;
        sysclk     = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        fb_valid   = 1'b0;
        fb_data    = {NUM_AXES{qla_pkg::MIDSCALE}};
        reset_model();
        repeat (10) @(posedge sysclk);
        #2;
        rst = 1'b0;
        reset_state();
        dac_readback();
        feedback_capture();
        safety_trip();
        clear_reenable();
        board_and_unmapped();
        backpressure_order();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- qla_axes.f
+incdir+verif
source/qla_pkg.sv
source/reg_decode.sv
source/axis_channel.sv
source/board_regs.sv
source/read_mux.sv
source/qla_axes.sv
verif/qla_axes_tb.sv

//--- Makefile
# Verilator build and run for the qla_axes testbench

VERILATOR ?= verilator
TOP       ?= qla_axes_tb
FILELIST  ?= qla_axes.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST)) verif/qla_model.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
